// ==== logic/alu.sv ====
`timescale 1ns/1ps

module alu (
  input  retro_pkg::decoded_t dec,
  input  retro_pkg::word_t    pc,
  input  retro_pkg::word_t    rs1_val,
  input  retro_pkg::word_t    rs2_val,
  output retro_pkg::word_t    result,
  output retro_pkg::word_t    next_pc
);

  retro_pkg::word_t op_b;
  retro_pkg::word_t alu_out;
  retro_pkg::word_t pc_plus4;
  logic             taken;

  assign op_b     = (dec.op_class == retro_pkg::C_OP_REG) ? rs2_val : dec.imm;
  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    case (dec.alu_fn)
      retro_pkg::A_SUB:  alu_out = rs1_val - op_b;
      retro_pkg::A_SLL:  alu_out = rs1_val << op_b[4:0];
      retro_pkg::A_SLT:  alu_out = {31'b0, $signed(rs1_val) < $signed(op_b)};
      retro_pkg::A_SLTU: alu_out = {31'b0, rs1_val < op_b};
      retro_pkg::A_XOR:  alu_out = rs1_val ^ op_b;
      retro_pkg::A_SRL:  alu_out = rs1_val >> op_b[4:0];
      retro_pkg::A_SRA:  alu_out = $unsigned($signed(rs1_val) >>> op_b[4:0]);
      retro_pkg::A_OR:   alu_out = rs1_val | op_b;
      retro_pkg::A_AND:  alu_out = rs1_val & op_b;
      default:           alu_out = rs1_val + op_b;  // also store ea and jalr target
    endcase
  end

  always_comb begin
    case (dec.br_cond)
      3'b000:  taken = rs1_val == rs2_val;
      3'b001:  taken = rs1_val != rs2_val;
      3'b100:  taken = $signed(rs1_val) < $signed(rs2_val);
      3'b101:  taken = $signed(rs1_val) >= $signed(rs2_val);
      3'b110:  taken = rs1_val < rs2_val;
      default: taken = rs1_val >= rs2_val;
    endcase
  end

  always_comb begin
    result  = alu_out;
    next_pc = pc_plus4;
    case (dec.op_class)
      retro_pkg::C_LUI:   result = dec.imm;
      retro_pkg::C_AUIPC: result = pc + dec.imm;
      retro_pkg::C_JAL: begin
        result  = pc_plus4;           // link
        next_pc = pc + dec.imm;
      end
      retro_pkg::C_JALR: begin
        result  = pc_plus4;
        next_pc = {alu_out[31:1], 1'b0};
      end
      retro_pkg::C_BRANCH: next_pc = taken ? pc + dec.imm : pc_plus4;
      default: result = alu_out;
    endcase
  end

endmodule

// ==== logic/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
  input  retro_pkg::word_t    inst,
  output retro_pkg::decoded_t dec
);

  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic             alt;            // funct7 bit 5
  retro_pkg::word_t imm_i;
  retro_pkg::word_t imm_s;
  retro_pkg::word_t imm_b;
  retro_pkg::word_t imm_u;
  retro_pkg::word_t imm_j;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign alt    = inst[30];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  function automatic retro_pkg::alu_fn_t fn_of(input logic [2:0] f3, input logic sub_sra);
    case (f3)
      3'b000:  fn_of = sub_sra ? retro_pkg::A_SUB : retro_pkg::A_ADD;
      3'b001:  fn_of = retro_pkg::A_SLL;
      3'b010:  fn_of = retro_pkg::A_SLT;
      3'b011:  fn_of = retro_pkg::A_SLTU;
      3'b100:  fn_of = retro_pkg::A_XOR;
      3'b101:  fn_of = sub_sra ? retro_pkg::A_SRA : retro_pkg::A_SRL;
      3'b110:  fn_of = retro_pkg::A_OR;
      default: fn_of = retro_pkg::A_AND;
    endcase
  endfunction

  always_comb begin
    dec.op_class = retro_pkg::C_NOP;
    dec.alu_fn   = retro_pkg::A_ADD;
    dec.br_cond  = funct3;
    dec.size     = funct3[1:0];
    dec.rd       = inst[11:7];
    dec.rs1      = inst[19:15];
    dec.rs2      = inst[24:20];
    dec.imm      = imm_i;
    case (opcode)
      7'b0110111: begin
        dec.op_class = retro_pkg::C_LUI;
        dec.imm      = imm_u;
      end
      7'b0010111: begin
        dec.op_class = retro_pkg::C_AUIPC;
        dec.imm      = imm_u;
      end
      7'b1101111: begin
        dec.op_class = retro_pkg::C_JAL;
        dec.imm      = imm_j;
      end
      7'b1100111: begin
        if (funct3 == 3'b000) begin
          dec.op_class = retro_pkg::C_JALR;
        end
      end
      7'b1100011: begin
        dec.imm = imm_b;
        if (funct3[2:1] != 2'b01) begin     // 010 and 011 are reserved
          dec.op_class = retro_pkg::C_BRANCH;
        end
      end
      7'b0010011: begin
        dec.op_class = retro_pkg::C_OP_IMM;
        dec.alu_fn   = fn_of(funct3, alt && funct3 == 3'b101);
        if (funct3[1:0] == 2'b01) begin
          dec.imm = {27'b0, inst[24:20]};  // shamt only
        end
      end
      7'b0110011: begin
        dec.op_class = retro_pkg::C_OP_REG;
        dec.alu_fn   = fn_of(funct3, alt);
      end
      7'b0100011: begin
        dec.imm = imm_s;
        if (!funct3[2] && funct3[1:0] != 2'b11) begin
          dec.op_class = retro_pkg::C_STORE;
        end
      end
      default: dec.op_class = retro_pkg::C_NOP;  // fence, system, loads
    endcase
    if (dec.op_class inside {retro_pkg::C_BRANCH, retro_pkg::C_STORE, retro_pkg::C_NOP}) begin
      dec.rd = '0;
    end
  end

endmodule

// ==== logic/instr_sequencer.sv ====
`timescale 1ns/1ps
`include "retro_config.svh"

module instr_sequencer (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                hold,
  input  retro_pkg::byte_t    data_in,
  input  retro_pkg::decoded_t dec,
  input  retro_pkg::word_t    next_pc,
  input  logic                store_done,
  output retro_pkg::word_t    inst,
  output retro_pkg::word_t    pc,
  output retro_pkg::addr_t    fetch_addr,
  output logic                rd_we,
  output logic                store_start
);

  retro_pkg::seq_state_t state;
  logic [1:0]            byte_idx;
  logic                  fetching;
  logic                  writes_rd;

  always_comb begin
    fetching = 1'b1;
    case (state)
      retro_pkg::S_FETCH0: byte_idx = 2'd0;
      retro_pkg::S_FETCH1: byte_idx = 2'd1;
      retro_pkg::S_FETCH2: byte_idx = 2'd2;
      retro_pkg::S_FETCH3: byte_idx = 2'd3;
      default: begin
        byte_idx = 2'd0;
        fetching = 1'b0;
      end
    endcase
  end

  assign fetch_addr = pc[`RETRO_ADDR_W-1:0] + retro_pkg::addr_t'(byte_idx);

  assign writes_rd = dec.op_class inside {retro_pkg::C_LUI, retro_pkg::C_AUIPC,
                                          retro_pkg::C_JAL, retro_pkg::C_JALR,
                                          retro_pkg::C_OP_IMM, retro_pkg::C_OP_REG};

  // single accepted EXEC cycle, so one pulse each
  assign rd_we       = (state == retro_pkg::S_EXEC) && !hold && writes_rd;
  assign store_start = (state == retro_pkg::S_EXEC) && !hold &&
                       (dec.op_class == retro_pkg::C_STORE);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= retro_pkg::S_FETCH0;
      pc    <= `RETRO_START_ADDR;
    end else if (!hold) begin
      case (state)
        retro_pkg::S_FETCH0: state <= retro_pkg::S_FETCH1;
        retro_pkg::S_FETCH1: state <= retro_pkg::S_FETCH2;
        retro_pkg::S_FETCH2: state <= retro_pkg::S_FETCH3;
        retro_pkg::S_FETCH3: state <= retro_pkg::S_EXEC;
        retro_pkg::S_EXEC: begin
          pc    <= next_pc;
          state <= (dec.op_class == retro_pkg::C_STORE) ? retro_pkg::S_STORE
                                                        : retro_pkg::S_FETCH0;
        end
        retro_pkg::S_STORE: begin
          if (store_done) begin
            state <= retro_pkg::S_FETCH0;
          end
        end
        default: state <= retro_pkg::S_FETCH0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!hold && fetching) begin
      inst[{byte_idx, 3'b000} +: 8] <= data_in;  // little-endian lanes
    end
  end

  assert property (@(posedge clk) disable iff (!arst_n) !(rd_we && store_start));

  // stores are only entered from execute
  assert property (@(posedge clk) disable iff (!arst_n)
    (state == retro_pkg::S_STORE && $past(state) != retro_pkg::S_STORE)
      |-> $past(state) == retro_pkg::S_EXEC);

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps
`include "retro_config.svh"

module reg_file (
  input  logic                clk,
  input  logic                arst_n,
  input  retro_pkg::reg_idx_t rs1,
  input  retro_pkg::reg_idx_t rs2,
  input  retro_pkg::reg_idx_t rd,
  input  logic                rd_we,
  input  retro_pkg::word_t    rd_val,
  output retro_pkg::word_t    rs1_val,
  output retro_pkg::word_t    rs2_val
);

  retro_pkg::word_t regs [`RETRO_REG_NUM];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `RETRO_REG_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we && rd != '0) begin   // x0 stays zero
      regs[rd] <= rd_val;
    end
  end

  assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== logic/retro_config.svh ====
`ifndef RETRO_CONFIG_SVH
`define RETRO_CONFIG_SVH

// memory bus address width in bits
`define RETRO_ADDR_W 16

// general purpose registers, x0 included
`define RETRO_REG_NUM 32

// program counter value after reset
`define RETRO_START_ADDR 32'h0000_0000

`endif

// ==== logic/retro_core.sv ====
`timescale 1ns/1ps

module retro_core (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              hold,
  output retro_pkg::addr_t  address,
  input  retro_pkg::byte_t  data_in,
  output retro_pkg::byte_t  data_out,
  output logic              wren
);

  retro_pkg::word_t    inst;
  retro_pkg::word_t    pc;
  retro_pkg::addr_t    fetch_addr;
  retro_pkg::decoded_t dec;
  retro_pkg::word_t    rs1_val;
  retro_pkg::word_t    rs2_val;
  retro_pkg::word_t    result;
  retro_pkg::word_t    next_pc;
  logic                rd_we;
  logic                store_start;
  logic                store_done;

  instr_sequencer u_seq (
    .clk         (clk),
    .arst_n      (arst_n),
    .hold        (hold),
    .data_in     (data_in),
    .dec         (dec),
    .next_pc     (next_pc),
    .store_done  (store_done),
    .inst        (inst),
    .pc          (pc),
    .fetch_addr  (fetch_addr),
    .rd_we       (rd_we),
    .store_start (store_start)
  );

  instr_decoder u_dec (
    .inst (inst),
    .dec  (dec)
  );

  reg_file u_regs (
    .clk     (clk),
    .arst_n  (arst_n),
    .rs1     (dec.rs1),
    .rs2     (dec.rs2),
    .rd      (dec.rd),
    .rd_we   (rd_we),
    .rd_val  (result),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val)
  );

  alu u_alu (
    .dec     (dec),
    .pc      (pc),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .result  (result),
    .next_pc (next_pc)
  );

  store_unit u_store (
    .clk         (clk),
    .arst_n      (arst_n),
    .hold        (hold),
    .store_start (store_start),
    .ea          (result),                 // rs1 + imm for stores
    .wdata       (rs2_val),
    .size        (dec.size),
    .fetch_addr  (fetch_addr),
    .address     (address),
    .data_out    (data_out),
    .wren        (wren),
    .store_done  (store_done)
  );

endmodule

// ==== logic/retro_pkg.sv ====
`include "retro_config.svh"

package retro_pkg;

  typedef logic [31:0]              word_t;
  typedef logic [`RETRO_ADDR_W-1:0] addr_t;
  typedef logic [4:0]               reg_idx_t;
  typedef logic [7:0]               byte_t;

  typedef enum logic [2:0] {
    S_FETCH0,
    S_FETCH1,
    S_FETCH2,
    S_FETCH3,
    S_EXEC,
    S_STORE                         // waiting for the byte-serial write
  } seq_state_t;

  typedef enum logic [3:0] {
    C_LUI, C_AUIPC, C_JAL, C_JALR, C_BRANCH,
    C_OP_IMM, C_OP_REG, C_STORE, C_NOP
  } op_class_t;

  typedef enum logic [3:0] {
    A_ADD, A_SUB, A_SLL, A_SLT, A_SLTU,
    A_XOR, A_SRL, A_SRA, A_OR, A_AND
  } alu_fn_t;

  typedef struct packed {
    op_class_t op_class;
    alu_fn_t   alu_fn;
    logic [2:0] br_cond;            // funct3 of a branch
    logic [1:0] size;               // store size, log2 of bytes
    reg_idx_t  rd;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    word_t     imm;                 // sign extended
  } decoded_t;

endpackage

// ==== logic/store_unit.sv ====
`timescale 1ns/1ps
`include "retro_config.svh"

module store_unit (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             hold,
  input  logic             store_start,
  input  retro_pkg::word_t ea,
  input  retro_pkg::word_t wdata,
  input  logic [1:0]       size,
  input  retro_pkg::addr_t fetch_addr,
  output retro_pkg::addr_t address,
  output retro_pkg::byte_t data_out,
  output logic             wren,
  output logic             store_done
);

  logic [2:0]       remain;         // bytes left incl. current
  retro_pkg::addr_t st_addr;
  logic [23:0]      pending;        // upper bytes not yet on the bus
  logic             busy;

  assign busy       = remain != 3'd0;
  assign address    = busy ? st_addr : fetch_addr;
  assign wren       = busy && !hold;
  assign store_done = busy && remain == 3'd1;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      remain   <= '0;
      data_out <= '0;
    end else if (!hold) begin
      if (store_start) begin
        case (size)
          2'b00:   remain <= 3'd1;
          2'b01:   remain <= 3'd2;
          default: remain <= 3'd4;
        endcase
        data_out <= wdata[7:0];         // byte 0 goes out first
      end else if (busy) begin
        remain   <= remain - 3'd1;
        data_out <= pending[7:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!hold) begin
      if (store_start) begin
        st_addr <= ea[`RETRO_ADDR_W-1:0];
        pending <= wdata[31:8];
      end else if (busy) begin
        st_addr <= st_addr + retro_pkg::addr_t'(1);
        pending <= pending >> 8;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!arst_n) store_start |-> !busy);

endmodule

// ==== retro_core.f ====
+incdir+logic
+incdir+verification
logic/retro_pkg.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/alu.sv
logic/store_unit.sv
logic/instr_sequencer.sv
logic/retro_core.sv
verification/tb_retro_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the retro_core testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_retro_core -f retro_core.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SOME TESTS FAILED" sim.log; then
  exit 1
fi
exit 0

// ==== verification/tb_retro_tests.svh ====
`ifndef TB_RETRO_TESTS_SVH
`define TB_RETRO_TESTS_SVH

localparam logic [6:0] OP_IMM = 7'b0010011;
localparam logic [6:0] OP_REG = 7'b0110011;

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, OP_REG};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs1,
                                      input logic [4:0] rs2, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] op);
  return {imm, rd, op};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

// arithmetic shift right built from a logical shift and a sign mask
function automatic logic [31:0] sra_ref(input logic [31:0] v, input logic [4:0] s);
  return (v >> s) | (v[31] ? ~(32'hffff_ffff >> s) : 32'h0);
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
  logic lt_u;
  logic lt_s;
  lt_u = a < b;
  lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);  // signed order via flipped sign bits
  case (f3)
    3'b000:  return a == b;
    3'b001:  return a != b;
    3'b100:  return lt_s;
    3'b101:  return !lt_s;
    3'b110:  return lt_u;
    default: return !lt_u;
  endcase
endfunction

task automatic emit(input logic [31:0] w);
  for (int i = 0; i < 4; i++) begin
    mem[prog_pc[15:0] + 16'(i)] = w[8*i +: 8];  // little-endian
  end
  prog_pc = prog_pc + 32'd4;
endtask

task automatic begin_test();
  for (int i = 0; i < 65536; i++) begin
    mem[16'(i)] = 8'h00;
  end
  prog_pc     = '0;
  st_ptr      = 16'h0400;
  test_errors = 0;
  expect_q.delete();
endtask

task automatic expect_store(input logic [15:0] a, input logic [31:0] v, input int n);
  for (int i = 0; i < n; i++) begin
    expect_q.push_back({a + 16'(i), v[8*i +: 8]});
  end
endtask

task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
  logic [31:0] hi;
  hi = v + 32'h800;                     // compensate for addi sign extension
  emit(enc_u(hi[31:12], rd, 7'b0110111));
  emit(enc_i(v[11:0], rd, 3'b000, rd, OP_IMM));
endtask

// runs one instruction that writes x10, then stores x10 as a word
task automatic alu_case(input logic [31:0] instr, input logic [31:0] exp);
  emit(instr);
  emit(enc_s(st_ptr[11:0], 5'd10, 5'd0, 3'b010));
  expect_store(st_ptr, exp, 4);
  st_ptr = st_ptr + 16'd4;
endtask

task automatic run_program();
  @(posedge clk);
  arst_n <= 1'b0;
  repeat (10) @(posedge clk);
  wlog.delete();
  arst_n <= 1'b1;
  while (wlog.size() < expect_q.size()) begin
    @(posedge clk);
  end
  repeat (20) @(posedge clk);           // catch stray writes
endtask

task automatic compare_log(input string name);
  int n;
  assert (wlog.size() == expect_q.size()) else begin
    $display("Fail %s: expected %0d writes, actual %0d", name, expect_q.size(), wlog.size());
    test_errors++;
  end
  n = (wlog.size() < expect_q.size()) ? wlog.size() : expect_q.size();
  for (int i = 0; i < n; i++) begin
    assert (wlog[i] == expect_q[i]) else begin
      $display("Fail %s: write %0d expected %h actual %h", name, i, expect_q[i], wlog[i]);
      test_errors++;
    end
  end
  tests_run++;
  errors = errors + test_errors;
  if (test_errors != 0) begin
    tests_failed++;
  end
  $display("%s: %s", name, (test_errors == 0) ? "ok" : "wrong writes");
endtask

task automatic finish_and_check(input string name);
  emit(enc_j(21'd0, 5'd0));             // jump to itself
  run_program();
  compare_log(name);
endtask

task automatic test_alu_ops();
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] c;
  logic [31:0] d;
  a = 32'h8000_0000;
  b = 32'h7fff_ffff;
  c = 32'hffff_ffff;
  d = 32'd5;
  begin_test();
  load_const(5'd1, a);
  load_const(5'd2, b);
  load_const(5'd3, c);
  load_const(5'd4, d);
  alu_case(enc_i(12'd1, 5'd2, 3'b000, 5'd10, OP_IMM), b + 32'd1);
  alu_case(enc_i(12'hfff, 5'd1, 3'b000, 5'd10, OP_IMM), a - 32'd1);
  alu_case(enc_r(7'b0, 5'd4, 5'd2, 3'b000, 5'd10), b + d);
  alu_case(enc_r(7'b0100000, 5'd4, 5'd1, 3'b000, 5'd10), a - d);
  alu_case(enc_r(7'b0, 5'd3, 5'd1, 3'b100, 5'd10), a ^ c);
  alu_case(enc_r(7'b0, 5'd4, 5'd2, 3'b110, 5'd10), b | d);
  alu_case(enc_r(7'b0, 5'd4, 5'd3, 3'b111, 5'd10), c & d);
  alu_case(enc_r(7'b0, 5'd2, 5'd1, 3'b010, 5'd10), {31'b0, $signed(a) < $signed(b)});
  alu_case(enc_r(7'b0, 5'd2, 5'd1, 3'b011, 5'd10), {31'b0, a < b});
  alu_case(enc_i(12'd0, 5'd3, 3'b010, 5'd10, OP_IMM), {31'b0, $signed(c) < 0});
  alu_case(enc_i(12'hfff, 5'd4, 3'b011, 5'd10, OP_IMM), {31'b0, d < 32'hffff_ffff});
  finish_and_check("alu_ops");
endtask

task automatic test_shifts();
  logic [31:0] v;
  logic [4:0]  s;
  logic [4:0]  r;
  v = 32'h8000_0001;                    // negative operand
  begin_test();
  load_const(5'd1, v);
  emit(enc_i(12'd1, 5'd0, 3'b000, 5'd5, OP_IMM));
  emit(enc_i(12'd31, 5'd0, 3'b000, 5'd6, OP_IMM));
  for (int i = 0; i < 3; i++) begin
    s = (i == 0) ? 5'd0 : (i == 1) ? 5'd1 : 5'd31;
    r = (i == 0) ? 5'd0 : (i == 1) ? 5'd5 : 5'd6;  // register holding s
    alu_case(enc_i({7'b0, s}, 5'd1, 3'b001, 5'd10, OP_IMM), v << s);
    alu_case(enc_i({7'b0, s}, 5'd1, 3'b101, 5'd10, OP_IMM), v >> s);
    alu_case(enc_i({7'b0100000, s}, 5'd1, 3'b101, 5'd10, OP_IMM), sra_ref(v, s));
    alu_case(enc_r(7'b0, r, 5'd1, 3'b001, 5'd10), v << s);
    alu_case(enc_r(7'b0, r, 5'd1, 3'b101, 5'd10), v >> s);
    alu_case(enc_r(7'b0100000, r, 5'd1, 3'b101, 5'd10), sra_ref(v, s));
  end
  finish_and_check("shifts");
endtask

task automatic test_branches();
  logic [2:0]  f3;
  logic [4:0]  ra;
  logic [4:0]  rb;
  logic [7:0]  m_nt;
  logic [7:0]  m_t;
  logic [31:0] va;
  logic [31:0] vb;
  begin_test();
  emit(enc_i(12'hfff, 5'd0, 3'b000, 5'd1, OP_IMM));  // x1 = -1
  emit(enc_i(12'd1, 5'd0, 3'b000, 5'd2, OP_IMM));    // x2 = 1
  for (int b = 0; b < 6; b++) begin
    f3 = (b < 2) ? 3'(b) : 3'(b + 2);
    for (int p = 0; p < 3; p++) begin
      ra   = (p == 1) ? 5'd2 : 5'd1;
      rb   = (p == 0) ? 5'd2 : 5'd1;
      va   = (ra == 5'd1) ? 32'hffff_ffff : 32'd1;
      vb   = (rb == 5'd1) ? 32'hffff_ffff : 32'd1;
      m_nt = 8'(2 * (b * 3 + p) + 1);
      m_t  = 8'(2 * (b * 3 + p) + 2);
      emit(enc_i({4'b0, m_nt}, 5'd0, 3'b000, 5'd10, OP_IMM));
      emit(enc_i({4'b0, m_t}, 5'd0, 3'b000, 5'd11, OP_IMM));
      emit(enc_b(13'd12, ra, rb, f3));
      emit(enc_s(st_ptr[11:0], 5'd10, 5'd0, 3'b000));  // fall-through path
      emit(enc_j(21'd8, 5'd0));
      emit(enc_s(st_ptr[11:0], 5'd11, 5'd0, 3'b000));  // taken path
      expect_store(st_ptr, {24'b0, branch_taken(f3, va, vb) ? m_t : m_nt}, 1);
      st_ptr = st_ptr + 16'd1;
    end
  end
  finish_and_check("branches");
endtask

task automatic test_jumps_upper();
  logic [31:0] p;
  logic [31:0] t;
  begin_test();
  alu_case(enc_u(20'h12345, 5'd10, 7'b0110111), 32'h1234_5000);
  p = prog_pc;
  alu_case(enc_u(20'hfffff, 5'd10, 7'b0010111), p + 32'hffff_f000);
  p = prog_pc;
  emit(enc_j(21'd8, 5'd10));
  emit(enc_s(12'h7f0, 5'd0, 5'd0, 3'b010));          // skipped by the jump
  alu_case(enc_i(12'd0, 5'd10, 3'b000, 5'd10, OP_IMM), p + 32'd4);
  t = prog_pc + 32'd12;
  emit(enc_i(t[11:0], 5'd0, 3'b000, 5'd5, OP_IMM));
  p = prog_pc;
  emit(enc_i(12'd1, 5'd5, 3'b000, 5'd10, 7'b1100111));  // jalr to an odd target
  emit(enc_s(12'h7f4, 5'd0, 5'd0, 3'b010));
  alu_case(enc_i(12'd0, 5'd10, 3'b000, 5'd10, OP_IMM), p + 32'd4);
  finish_and_check("jumps_upper");
endtask

task automatic build_store_prog();
  load_const(5'd1, 32'h1122_3344);
  emit(enc_i(12'h700, 5'd0, 3'b000, 5'd2, OP_IMM));
  emit(enc_s(12'h501, 5'd1, 5'd0, 3'b000));
  expect_store(16'h0501, 32'h1122_3344, 1);
  emit(enc_s(12'h603, 5'd1, 5'd0, 3'b001));
  expect_store(16'h0603, 32'h1122_3344, 2);
  emit(enc_s(12'd5, 5'd1, 5'd2, 3'b010));
  expect_store(16'h0705, 32'h1122_3344, 4);
  emit(enc_i(12'd123, 5'd0, 3'b000, 5'd0, OP_IMM));  // x0 ignores writes
  emit(32'h0000_000f);                               // fence
  emit(enc_s(12'h710, 5'd0, 5'd0, 3'b010));
  expect_store(16'h0710, 32'h0, 4);
endtask

task automatic test_store_sizes();
  begin_test();
  build_store_prog();
  finish_and_check("store_sizes");
endtask

// same program and same expected log as the store test, with random stalls
task automatic test_hold();
  begin_test();
  build_store_prog();
  hold_en = 1'b1;
  finish_and_check("hold");
  hold_en = 1'b0;
endtask

`endif

// ==== verification/tb_retro_core.sv ====
`timescale 1ns/1ps

module tb_retro_core;

  localparam int TIMEOUT_CYCLES = 3000;  // 6 tests x 400 plus reset

  logic        clk;
  logic        arst_n;
  logic        hold;
  logic [15:0] address;
  logic [7:0]  data_in;
  logic [7:0]  data_out;
  logic        wren;

  logic [7:0]  mem [65536];             // byte wide program and data memory
  logic [23:0] wlog [$];                // {address, byte} per write cycle
  logic [23:0] expect_q [$];

  int          cycles;
  int          errors;
  int          test_errors;
  int          tests_run;
  int          tests_failed;
  integer      seed;
  logic        hold_en;
  logic [31:0] prog_pc;                 // next free program slot
  logic [15:0] st_ptr;                  // next free store address

  retro_core DUT (
    .clk      (clk),
    .arst_n   (arst_n),
    .hold     (hold),
    .address  (address),
    .data_in  (data_in),
    .data_out (data_out),
    .wren     (wren)
  );

  assign data_in = mem[address];        // same cycle read

  always #10 clk = ~clk;

  always @(posedge clk) begin
    hold <= hold_en && (($random(seed) & 32'sd3) == 32'sd0);
  end

  // write monitor
  always @(posedge clk) begin
    if (arst_n && wren) begin
      wlog.push_back({address, data_out});
      mem[address] <= data_out;
    end
    if (arst_n) begin
      assert (!(wren && hold)) else begin
        $display("write strobe seen while hold is high, address %h", address);
        test_errors++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the core stopped writing", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  `include "tb_retro_tests.svh"

  initial begin
    clk          = 1'b0;
    arst_n       = 1'b0;
    hold         = 1'b0;
    hold_en      = 1'b0;
    seed         = 32'h94de11c9;
    cycles       = 0;
    errors       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    prog_pc      = '0;
    st_ptr       = 16'h0400;
    test_alu_ops();
    test_shifts();
    test_branches();
    test_jumps_upper();
    test_store_sizes();
    test_hold();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
